/* logic/osd_pkg.sv */
`default_nettype none

package osd_pkg;

    // raster coordinates
    parameter int COORD_W = 12;
    typedef logic [COORD_W-1:0] coord_t;

    // panel settings
    parameter int VALUE_W = 11;
    typedef logic [VALUE_W-1:0] value_t;
    typedef logic [3:0] digit_t;

    // 8x8 glyphs, bit 7 is the leftmost pixel
    parameter int FONT_W = 8;
    parameter int FONT_H = 8;
    typedef logic [FONT_W-1:0] glyph_row_t;
    typedef logic [6:0] font_addr_t;
    parameter int GLYPH_MARGIN = 2;

    typedef logic [15:0] rgb_t;
    parameter rgb_t COLOR_INK = 16'h0000;
    parameter rgb_t COLOR_PAPER = 16'hFFFF;

endpackage

`default_nettype wire

/* logic/digit_split.sv */
`timescale 1ns/10ps
`default_nettype none

module digit_split
    import osd_pkg::*;
(
    input  value_t value,
    output digit_t hundreds,
    output digit_t tens,
    output digit_t ones
);

    value_t by_hundred;
    value_t by_ten;

    assign by_hundred = value / value_t'(100);
    assign by_ten = value / value_t'(10);

    // values above 999 wrap the hundreds digit
    assign hundreds = digit_t'(by_hundred % value_t'(10));
    assign tens = digit_t'(by_ten % value_t'(10));
    assign ones = digit_t'(value % value_t'(10));

endmodule

`default_nettype wire

/* logic/keypad_locator.sv */
`timescale 1ns/10ps
`default_nettype none

module keypad_locator
    import osd_pkg::*;
#(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
)(
    input  coord_t     act_x,
    input  coord_t     act_y,
    output logic       hit,
    output digit_t     digit,
    output logic [2:0] glyph_row,
    output logic [2:0] glyph_col
);

    localparam coord_t CELL_W = coord_t'(H_ACT / 6);
    localparam coord_t CELL_H = coord_t'(V_ACT / 4);

    coord_t cell_x;
    coord_t cell_y;
    coord_t box_x;
    coord_t box_y;
    logic   in_key;

    assign cell_x = act_x / CELL_W;
    assign cell_y = act_y / CELL_H;

    // offset inside the glyph box; wraps high when left of or above it
    assign box_x = act_x - cell_x * CELL_W - coord_t'(GLYPH_MARGIN);
    assign box_y = act_y - cell_y * CELL_H - coord_t'(GLYPH_MARGIN);

    // 1..9 in rows 0..2, zero centred on row 3
    always_comb
    begin
        in_key = 1'b0;
        digit = '0;
        if (cell_x < 3 && cell_y < 3)
        begin
            in_key = 1'b1;
            digit = digit_t'(cell_y * 3 + cell_x + 1);
        end
        else if (cell_y == 3 && cell_x == 1)
        begin
            in_key = 1'b1;
        end
    end

    assign hit = in_key && (box_x < coord_t'(FONT_W)) && (box_y < coord_t'(FONT_H));
    assign glyph_col = box_x[2:0];
    assign glyph_row = box_y[2:0];

endmodule

`default_nettype wire

/* logic/readout_locator.sv */
`timescale 1ns/10ps
`default_nettype none

module readout_locator
    import osd_pkg::*;
#(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
)(
    input  coord_t     act_x,
    input  coord_t     act_y,
    input  value_t     target_vpp,
    input  value_t     target_freq,
    input  value_t     target_phase,
    output logic       hit,
    output digit_t     digit,
    output logic [2:0] glyph_row,
    output logic [2:0] glyph_col
);

    localparam coord_t CELL_H = coord_t'(V_ACT / 4);
    localparam coord_t ORG_X = coord_t'(H_ACT / 2 + GLYPH_MARGIN);

    value_t freq_shown;
    digit_t vpp_h, vpp_t, vpp_o;
    digit_t frq_h, frq_t, frq_o;
    digit_t phs_h, phs_t, phs_o;
    logic [11:0] row_digits;
    coord_t cell_y;
    coord_t rel_x;
    coord_t box_y;

    // kilo scaling
    assign freq_shown = (target_freq >= value_t'(1000)) ?
                        target_freq / value_t'(1000) : target_freq;

    digit_split u_split_vpp (.value(target_vpp), .hundreds(vpp_h), .tens(vpp_t), .ones(vpp_o));
    digit_split u_split_frq (.value(freq_shown), .hundreds(frq_h), .tens(frq_t), .ones(frq_o));
    digit_split u_split_phs (.value(target_phase), .hundreds(phs_h), .tens(phs_t), .ones(phs_o));

    assign cell_y = act_y / CELL_H;
    assign rel_x = act_x - ORG_X;
    assign box_y = act_y - cell_y * CELL_H - coord_t'(GLYPH_MARGIN);

    always_comb
    begin
        case (cell_y[1:0])
            2'd0: row_digits = {vpp_h, vpp_t, vpp_o};
            2'd1: row_digits = {frq_h, frq_t, frq_o};
            2'd2: row_digits = {phs_h, phs_t, phs_o};
            default: row_digits = '0;
        endcase
        // glyph slot from x offset, hundreds first
        case (rel_x[4:3])
            2'd0: digit = row_digits[11:8];
            2'd1: digit = row_digits[7:4];
            default: digit = row_digits[3:0];
        endcase
    end

    assign hit = (cell_y < 3) && (rel_x < coord_t'(3 * FONT_W)) &&
                 (box_y < coord_t'(FONT_H));
    assign glyph_col = rel_x[2:0];
    assign glyph_row = box_y[2:0];

endmodule

`default_nettype wire

/* logic/font_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module font_arbiter
    import osd_pkg::*;
(
    input  wire        pix_clk,
    input  wire        rst_n,
    input  wire        kp_hit,
    input  digit_t     kp_digit,
    input  wire  [2:0] kp_row,
    input  wire  [2:0] kp_col,
    input  wire        ro_hit,
    input  digit_t     ro_digit,
    input  wire  [2:0] ro_row,
    input  wire  [2:0] ro_col,
    output font_addr_t font_addr,
    output logic       glyph_hit,
    output logic [2:0] glyph_col
);

    digit_t     sel_digit;
    logic [2:0] sel_row;

    // keypad wins when both hit
    assign sel_digit = kp_hit ? kp_digit : ro_digit;
    assign sel_row = kp_hit ? kp_row : ro_row;

    // the ROM registers the address, so hit and column follow one cycle later
    assign font_addr = font_addr_t'(sel_digit * FONT_H + sel_row);

    always_ff @(posedge pix_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            glyph_hit <= 1'b0;
            glyph_col <= '0;
        end
        else
        begin
            glyph_hit <= kp_hit | ro_hit;
            glyph_col <= kp_hit ? kp_col : ro_col;
        end
    end

endmodule

`default_nettype wire

/* logic/digit_font_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module digit_font_rom
    import osd_pkg::*;
(
    input  wire        pix_clk,
    input  font_addr_t font_addr,
    output glyph_row_t glyph_data
);

    // ten digits, FONT_H rows each
    glyph_row_t font_mem [0:10*FONT_H-1];

    initial
    begin
        $readmemh("logic/digit_font.hex", font_mem);
    end

    always_ff @(posedge pix_clk)
    begin
        glyph_data <= font_mem[font_addr];
    end

endmodule

`default_nettype wire

/* logic/pixel_shader.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_shader
    import osd_pkg::*;
(
    input  wire        pix_clk,
    input  wire        rst_n,
    input  wire        glyph_hit,
    input  wire  [2:0] glyph_col,
    input  glyph_row_t glyph_data,
    input  wire        vs_in,
    input  wire        hs_in,
    input  wire        de_in,
    output logic       vs_out,
    output logic       hs_out,
    output logic       de_out,
    output rgb_t       rgb_data
);

    logic vs_d1;
    logic hs_d1;
    logic de_d1;
    logic ink;

    // column 0 is the msb of the row
    assign ink = glyph_hit && glyph_data[3'(FONT_W - 1) - glyph_col];

    always_ff @(posedge pix_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vs_d1 <= 1'b0;
            hs_d1 <= 1'b0;
            de_d1 <= 1'b0;
            vs_out <= 1'b0;
            hs_out <= 1'b0;
            de_out <= 1'b0;
            rgb_data <= COLOR_PAPER;
        end
        else
        begin
            // syncs match the two-cycle pixel path
            vs_d1 <= vs_in;
            hs_d1 <= hs_in;
            de_d1 <= de_in;
            vs_out <= vs_d1;
            hs_out <= hs_d1;
            de_out <= de_d1;
            rgb_data <= ink ? COLOR_INK : COLOR_PAPER;
        end
    end

endmodule

`default_nettype wire

/* logic/osd_overlay_top.sv */
`timescale 1ns/10ps
`default_nettype none

module osd_overlay_top #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
)(
    input  wire             pix_clk,
    input  wire             rst_n,
    input  osd_pkg::coord_t act_x,
    input  osd_pkg::coord_t act_y,
    input  wire             vs_in,
    input  wire             hs_in,
    input  wire             de_in,
    input  osd_pkg::value_t target_vpp,
    input  osd_pkg::value_t target_freq,
    input  osd_pkg::value_t target_phase,
    output logic            vs_out,
    output logic            hs_out,
    output logic            de_out,
    output osd_pkg::rgb_t   rgb_data
);

    logic                   kp_hit;
    osd_pkg::digit_t        kp_digit;
    logic [2:0]             kp_row;
    logic [2:0]             kp_col;
    logic                   ro_hit;
    osd_pkg::digit_t        ro_digit;
    logic [2:0]             ro_row;
    logic [2:0]             ro_col;
    osd_pkg::font_addr_t    font_addr;
    logic                   glyph_hit;
    logic [2:0]             glyph_col;
    osd_pkg::glyph_row_t    glyph_data;

    keypad_locator #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_keypad (
        .act_x(act_x), .act_y(act_y),
        .hit(kp_hit), .digit(kp_digit), .glyph_row(kp_row), .glyph_col(kp_col)
    );

    readout_locator #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_readout (
        .act_x(act_x), .act_y(act_y),
        .target_vpp(target_vpp), .target_freq(target_freq), .target_phase(target_phase),
        .hit(ro_hit), .digit(ro_digit), .glyph_row(ro_row), .glyph_col(ro_col)
    );

    font_arbiter u_arbiter (
        .pix_clk(pix_clk), .rst_n(rst_n),
        .kp_hit(kp_hit), .kp_digit(kp_digit), .kp_row(kp_row), .kp_col(kp_col),
        .ro_hit(ro_hit), .ro_digit(ro_digit), .ro_row(ro_row), .ro_col(ro_col),
        .font_addr(font_addr), .glyph_hit(glyph_hit), .glyph_col(glyph_col)
    );

    digit_font_rom u_font_rom (
        .pix_clk(pix_clk), .font_addr(font_addr), .glyph_data(glyph_data)
    );

    pixel_shader u_shader (
        .pix_clk(pix_clk), .rst_n(rst_n),
        .glyph_hit(glyph_hit), .glyph_col(glyph_col), .glyph_data(glyph_data),
        .vs_in(vs_in), .hs_in(hs_in), .de_in(de_in),
        .vs_out(vs_out), .hs_out(hs_out), .de_out(de_out), .rgb_data(rgb_data)
    );

endmodule

`default_nettype wire

/* tb/osd_overlay_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module osd_overlay_tb
    import osd_pkg::*;
();

    localparam int H_ACT = 96;
    localparam int V_ACT = 64;
    localparam int FRAMES = 4;
    localparam int CYCLE_LIMIT = FRAMES * H_ACT * V_ACT + 100;

    logic   pix_clk = 1'b0;
    logic   rst_n;
    coord_t act_x;
    coord_t act_y;
    logic   vs_in;
    logic   hs_in;
    logic   de_in;
    value_t target_vpp;
    value_t target_freq;
    value_t target_phase;
    logic   vs_out;
    logic   hs_out;
    logic   de_out;
    rgb_t   rgb_data;

    glyph_row_t font_ref [0:10*FONT_H-1];

    // expected outputs with index 2 due on the outputs now
    logic exp_vs [0:2];
    logic exp_hs [0:2];
    logic exp_de [0:2];
    rgb_t exp_rgb [0:2];
    int   exp_x [0:2];
    int   exp_y [0:2];

    int cur_vpp;
    int cur_freq;
    int cur_phase;
    int checks = 0;
    int sync_errors = 0;
    int pixel_errors = 0;
    int cycle_count = 0;

    osd_overlay_top #(.H_ACT(H_ACT), .V_ACT(V_ACT)) dut (
        .pix_clk(pix_clk), .rst_n(rst_n),
        .act_x(act_x), .act_y(act_y),
        .vs_in(vs_in), .hs_in(hs_in), .de_in(de_in),
        .target_vpp(target_vpp), .target_freq(target_freq), .target_phase(target_phase),
        .vs_out(vs_out), .hs_out(hs_out), .de_out(de_out), .rgb_data(rgb_data)
    );

    always #5 pix_clk = ~pix_clk;

    // reference pixel from the layout and digit rules
    function automatic rgb_t expected_pixel(input int x, input int y, input int vpp,
                                            input int freq, input int phase);
        int cell_w;
        int cell_h;
        int cx;
        int cy;
        int gx;
        int gy;
        int shown;
        int dig;
        bit boxed;
        cell_w = H_ACT / 6;
        cell_h = V_ACT / 4;
        cx = x / cell_w;
        cy = y / cell_h;
        gy = y - cy * cell_h - GLYPH_MARGIN;
        gx = 0;
        dig = 0;
        shown = 0;
        boxed = 1'b0;
        if (cx < 3)
        begin
            // keypad half where the bottom row holds only the zero key
            gx = x - cx * cell_w - GLYPH_MARGIN;
            if (cy < 3)
            begin
                dig = 3 * cy + cx + 1;
                boxed = 1'b1;
            end
            else if (cx == 1)
            begin
                boxed = 1'b1;
            end
        end
        else if (cy < 3)
        begin
            gx = x - (H_ACT / 2 + GLYPH_MARGIN);
            case (cy)
                0: shown = vpp;
                1: shown = (freq >= 1000) ? freq / 1000 : freq;
                default: shown = phase;
            endcase
            boxed = (gx >= 0) && (gx < 3 * FONT_W);
            if (boxed)
            begin
                // hundreds, tens, ones from left to right
                case (gx / FONT_W)
                    0: dig = (shown / 100) % 10;
                    1: dig = (shown / 10) % 10;
                    default: dig = shown % 10;
                endcase
                gx = gx % FONT_W;
            end
        end
        if (!boxed || gx < 0 || gx >= FONT_W || gy < 0 || gy >= FONT_H)
            return COLOR_PAPER;
        if (font_ref[dig * FONT_H + gy][FONT_W - 1 - gx])
            return COLOR_INK;
        return COLOR_PAPER;
    endfunction

    task automatic show_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual, input int x, input int y);
        $display("[ERROR] %s expected 0x%h got 0x%h (pixel x=%0d y=%0d)",
                 name, expected, actual, x, y);
    endtask

    task automatic pick_settings(input bit kilo);
        cur_vpp = int'($urandom % 2048);
        cur_phase = int'($urandom % 2048);
        if (kilo)
            cur_freq = 1000 + int'($urandom % 1048);
        else
            cur_freq = int'($urandom % 1000);
    endtask

    task automatic drive_pixel(input int x, input int y, input logic vs, input logic hs,
                               input logic de);
        @(posedge pix_clk);
        act_x <= coord_t'(x);
        act_y <= coord_t'(y);
        vs_in <= vs;
        hs_in <= hs;
        de_in <= de;
        target_vpp <= value_t'(cur_vpp);
        target_freq <= value_t'(cur_freq);
        target_phase <= value_t'(cur_phase);
        for (int i = 2; i > 0; i--)
        begin
            exp_vs[i] = exp_vs[i-1];
            exp_hs[i] = exp_hs[i-1];
            exp_de[i] = exp_de[i-1];
            exp_rgb[i] = exp_rgb[i-1];
            exp_x[i] = exp_x[i-1];
            exp_y[i] = exp_y[i-1];
        end
        exp_vs[0] = vs;
        exp_hs[0] = hs;
        exp_de[0] = de;
        exp_rgb[0] = expected_pixel(x, y, cur_vpp, cur_freq, cur_phase);
        exp_x[0] = x;
        exp_y[0] = y;
    endtask

    // outputs are stable half a cycle after the edge
    always @(negedge pix_clk)
    begin
        checks = checks + 1;
        assert (vs_out === exp_vs[2])
        else
        begin
            sync_errors = sync_errors + 1;
            show_mismatch("vs_out", 16'(exp_vs[2]), 16'(vs_out), exp_x[2], exp_y[2]);
        end
        assert (hs_out === exp_hs[2])
        else
        begin
            sync_errors = sync_errors + 1;
            show_mismatch("hs_out", 16'(exp_hs[2]), 16'(hs_out), exp_x[2], exp_y[2]);
        end
        assert (de_out === exp_de[2])
        else
        begin
            sync_errors = sync_errors + 1;
            show_mismatch("de_out", 16'(exp_de[2]), 16'(de_out), exp_x[2], exp_y[2]);
        end
        assert (rgb_data === exp_rgb[2])
        else
        begin
            pixel_errors = pixel_errors + 1;
            show_mismatch("rgb_data", exp_rgb[2], rgb_data, exp_x[2], exp_y[2]);
        end
    end

    always @(posedge pix_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("run stopped after %0d cycles before the stimulus finished", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        int seed_init;
        seed_init = $urandom(11);
        $readmemh("logic/digit_font.hex", font_ref);
        rst_n = 1'b0;
        act_x = '0;
        act_y = '0;
        vs_in = 1'b0;
        hs_in = 1'b0;
        de_in = 1'b0;
        target_vpp = '0;
        target_freq = '0;
        target_phase = '0;
        cur_vpp = 0;
        cur_freq = 0;
        cur_phase = 0;
        for (int i = 0; i < 3; i++)
        begin
            exp_vs[i] = 1'b0;
            exp_hs[i] = 1'b0;
            exp_de[i] = 1'b0;
            exp_rgb[i] = COLOR_PAPER;
            exp_x[i] = 0;
            exp_y[i] = 0;
        end

        // idle raster during reset
        repeat (5) drive_pixel(0, 0, 1'b0, 1'b0, 1'b0);
        rst_n <= 1'b1;

        for (int f = 0; f < FRAMES; f++)
        begin
            pick_settings(f % 2 == 1);
            for (int y = 0; y < V_ACT; y++)
            begin
                for (int x = 0; x < H_ACT; x++)
                begin
                    drive_pixel(x, y, 1'($urandom % 2), 1'($urandom % 2), 1'b1);
                end
            end
        end

        // flush the two pixels still in flight
        repeat (3) drive_pixel(0, 0, 1'b0, 1'b0, 1'b0);
        @(negedge pix_clk);
        #1;
        $display("checks: %0d  sync errors: %0d  pixel errors: %0d",
                 checks, sync_errors, pixel_errors);
        if (sync_errors == 0 && pixel_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
logic/osd_pkg.sv
logic/digit_split.sv
logic/keypad_locator.sv
logic/readout_locator.sv
logic/font_arbiter.sv
logic/digit_font_rom.sv
logic/pixel_shader.sv
logic/osd_overlay_top.sv
tb/osd_overlay_tb.sv

/* Makefile */
TOP := osd_overlay_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -q "^No errors$$"

lint:
	verilator --lint-only --timing --assert -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* logic/digit_font.hex */
// glyph rows of digits 0 to 9 with eight rows each
// bit 7 of each row is the leftmost pixel
3C
66
6E
76
66
66
3C
00
18
38
18
18
18
18
7E
00
3C
66
06
0C
18
30
7E
00
3C
66
06
1C
06
66
3C
00
0C
1C
3C
6C
7E
0C
0C
00
7E
60
7C
06
06
66
3C
00
1C
30
60
7C
66
66
3C
00
7E
06
0C
18
30
30
30
00
3C
66
66
3C
66
66
3C
00
3C
66
66
3E
06
0C
38
00
